//--- project.f
+incdir+include
logic/cd_link_pkg.sv
logic/cd_host_rx.sv
logic/cd_host_tx.sv
logic/cd_data_streamer.sv
logic/cd_link_top.sv
tb/tb_clock_gen.sv
tb/cd_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CD link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module cd_link_tb \
	-f project.f --Mdir obj_dir -o cd_link_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cd_link_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation binary exited with status $run_status"
	exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb/cd_link_tb.sv
// CD-ROM host link testbench
// Drives the mailbox, request and download ports, keeps a model of
// the expected outputs and checks the DUT with concurrent assertions

`timescale 1ns/1ps

`include "cd_link_macros.svh"

module cd_link_tb;

	import cd_link_pkg::*;

	localparam int CLK_NS = 4;
	// Reset and the five tests, in clocks
	localparam int TEST_CYCLES = 12 + 4 + 16 + 24 + 16 + 48;

	logic                  clk_sys;
	logic                  reset;
	cd_host_word_t         host_word;
	cd_core_word_t         core_word;
	logic                  comm_send;
	logic [`CD_CMD_W-1:0]  comm;
	logic                  dout_send;
	logic [`CD_DOUT_W-1:0] dout;
	logic                  data_end;
	logic                  reset_req;
	logic                  fast_seek;
	logic                  dl_active;
	ioctl_t                dl;
	cd_status_t            status;
	logic                  stat_get;
	logic                  dout_req;
	logic                  region;
	cd_byte_t              cd_data;

	// Expected outputs
	logic          seen_toggle;
	logic          exp_stat_get;
	logic          exp_dout_req;
	logic          exp_region;
	cd_status_t    exp_status;
	cd_core_word_t exp_word;
	logic [3:0]    req_q;
	logic [3:0]    req_rise;
	logic [7:0]    exp_bytes [0:7];
	logic [7:0]    exp_byte;
	int            strobe_cnt;
	int            err_cnt;
	int            test_cnt;
	int            fail_cnt;

	tb_clock_gen clock_gen (.clk_sys(clk_sys), .reset(reset));

	cd_link_top dut0 (.*);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Rising requests with the command in the top bit
	assign req_rise = {comm_send, dout_send, data_end, reset_req} & ~req_q;
	assign exp_byte = exp_bytes[strobe_cnt[2:0]];

	always @(posedge clk_sys) begin
		if (reset) begin
			seen_toggle  <= 1'b1;
			exp_stat_get <= 1'b0;
			exp_dout_req <= 1'b0;
			exp_region   <= 1'b0;
			exp_word     <= '0;
			req_q        <= '0;
			strobe_cnt   <= 0;
		end else begin
			req_q        <= {comm_send, dout_send, data_end, reset_req};
			exp_stat_get <= (host_word.toggle != seen_toggle) && !host_word.dout_flag;
			exp_dout_req <= (host_word.toggle != seen_toggle) && host_word.dout_flag;
			if (host_word.toggle != seen_toggle) begin
				seen_toggle <= host_word.toggle;
				exp_region  <= host_word.region;
				exp_status  <= host_word.status;
			end
			if (req_rise != 4'b0000) begin
				exp_word.toggle <= ~exp_word.toggle;
			end
			if (req_rise[3]) begin
				exp_word.code    <= {fast_seek, 15'h0000};
				exp_word.payload <= comm;
			end else if (req_rise[2]) begin
				exp_word.code                    <= 16'h0001;
				exp_word.payload[`CD_DOUT_W-1:0] <= dout;
			end else if (req_rise[1]) begin
				exp_word.code <= 16'h0002;
			end else if (req_rise[0]) begin
				exp_word.code <= 16'h00FF;
			end
			if (cd_data.wr) begin
				strobe_cnt <= strobe_cnt + 1;
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		err_cnt++;
		$display("mismatch %s: got %0h expected %0h", name, got, exp);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////////////////////////

	reset_check: assert property (@(posedge clk_sys) reset |=> (core_word == '0 &&
		!stat_get && !dout_req && !region && !cd_data.wr))
		else report_mismatch("reset state {core_word,stat_get,dout_req,region,wr}",
			128'($sampled({core_word, stat_get, dout_req, region, cd_data.wr})), 128'(0));
	stat_get_check: assert property (@(posedge clk_sys) disable iff (reset)
		stat_get == exp_stat_get)
		else report_mismatch("stat_get",
			128'($sampled(stat_get)), 128'($sampled(exp_stat_get)));
	dout_req_check: assert property (@(posedge clk_sys) disable iff (reset)
		dout_req == exp_dout_req)
		else report_mismatch("dout_req",
			128'($sampled(dout_req)), 128'($sampled(exp_dout_req)));
	region_check: assert property (@(posedge clk_sys) disable iff (reset)
		region == exp_region)
		else report_mismatch("region", 128'($sampled(region)), 128'($sampled(exp_region)));
	// Status only counts on a new message
	status_check: assert property (@(posedge clk_sys) disable iff (reset)
		(exp_stat_get || exp_dout_req) |-> status == exp_status)
		else report_mismatch("status", 128'($sampled(status)), 128'($sampled(exp_status)));
	core_word_check: assert property (@(posedge clk_sys) disable iff (reset)
		core_word == exp_word)
		else report_mismatch("core_word",
			128'($sampled(core_word)), 128'($sampled(exp_word)));
	byte_data_check: assert property (@(posedge clk_sys) disable iff (reset)
		cd_data.wr |-> cd_data.data == exp_byte)
		else report_mismatch("cd_data.data",
			128'($sampled(cd_data.data)), 128'($sampled(exp_byte)));
	byte_dm_check: assert property (@(posedge clk_sys) disable iff (reset)
		cd_data.wr |-> cd_data.dm)
		else report_mismatch("cd_data.dm", 128'($sampled(cd_data.dm)), 128'(1));
	byte_pulse_check: assert property (@(posedge clk_sys) disable iff (reset)
		cd_data.wr |=> !cd_data.wr)
		else report_mismatch("cd_data.wr", 128'($sampled(cd_data.wr)), 128'(0));

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic send_host(input logic flag, input logic region_flag,
		input logic [15:0] bytes, input logic flip);
		host_word.toggle    = host_word.toggle ^ flip;
		host_word.dout_flag = flag;
		host_word.region    = region_flag;
		host_word.status    = bytes;
		wait_cycles(3);
	endtask

	task automatic pulse_dl(input logic [15:0] word, input int gap);
		dl.wr   = 1'b1;
		dl.data = word;
		wait_cycles(1);
		dl.wr   = 1'b0;
		wait_cycles(gap - 1);
	endtask

	task automatic finish_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
	endtask

	initial begin
		logic [95:0] rnd;
		int          err_before;
		void'($urandom(6));
		err_cnt          = 0;
		test_cnt         = 0;
		fail_cnt         = 0;
		host_word        = '0;
		host_word.toggle = 1'b1;
		comm_send        = 1'b0;
		comm             = '0;
		dout_send        = 1'b0;
		dout             = '0;
		data_end         = 1'b0;
		reset_req        = 1'b0;
		fast_seek        = 1'b0;
		dl_active        = 1'b0;
		dl               = '0;
		for (int k = 0; k < 8; k++) begin
			exp_bytes[k] = 8'h00;
		end

		// Reset state is checked while reset is still high
		err_before = err_cnt;
		wait (reset == 1'b0);
		wait_cycles(2);
		finish_test("reset state", err_before);

		// Status, then data-out, then a word with the toggle unchanged
		err_before = err_cnt;
		rnd = {$urandom, $urandom, $urandom};
		send_host(1'b0, 1'b1, rnd[15:0], 1'b1);
		send_host(1'b1, 1'b0, rnd[31:16], 1'b1);
		send_host(1'b0, 1'b1, rnd[47:32], 1'b0);
		finish_test("inbound status", err_before);

		// Requests stay high for a few clocks
		err_before = err_cnt;
		rnd       = {$urandom, $urandom, $urandom};
		comm      = rnd;
		fast_seek = 1'b1;
		comm_send = 1'b1;
		wait_cycles(3);
		comm_send = 1'b0;
		fast_seek = 1'b0;
		rnd       = {$urandom, $urandom, $urandom};
		dout      = rnd[`CD_DOUT_W-1:0];
		dout_send = 1'b1;
		wait_cycles(3);
		dout_send = 1'b0;
		comm      = ~comm;
		comm_send = 1'b1;
		wait_cycles(2);
		comm_send = 1'b0;
		wait_cycles(2);
		finish_test("outbound command and data-out", err_before);

		err_before = err_cnt;
		data_end   = 1'b1;
		reset_req  = 1'b1;
		wait_cycles(2);
		data_end   = 1'b0;
		reset_req  = 1'b0;
		wait_cycles(2);
		reset_req  = 1'b1;
		wait_cycles(2);
		reset_req  = 1'b0;
		wait_cycles(2);
		finish_test("priority and plain requests", err_before);

		// Header of mode 1 and three words, then one word too many
		err_before = err_cnt;
		rnd = {$urandom, $urandom, $urandom};
		for (int k = 0; k < 6; k++) begin
			exp_bytes[k] = rnd[8*k +: 8];
		end
		dl_active = 1'b1;
		wait_cycles(2);
		pulse_dl({1'b1, 15'd3}, 6);
		for (int i = 0; i < 4; i++) begin
			pulse_dl(rnd[16*i +: 16], 6);
		end
		wait_cycles(4);
		dl_active = 1'b0;
		assert (strobe_cnt == 6)
		else report_mismatch("cd_data.wr count", 128'(strobe_cnt), 128'(6));
		finish_test("sector streaming", err_before);

		$display("tests %0d, failed %0d, assertion errors %0d", test_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Twice the expected run length
	initial begin
		#(2 * TEST_CYCLES * CLK_NS);
		$display("timeout: tests did not reach the end");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb/tb_clock_gen.sv
// Clock and reset source for the CD link testbench
// clk_sys at a 4 ns period, reset held for the first 10 clocks

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Released on a falling edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

//--- logic/cd_link_top.sv
// CD-ROM host link top
// Inbound mailbox decoder, outbound mailbox and sector data
// streamer side by side on clk_sys

`timescale 1ns/1ps

`include "cd_link_macros.svh"

module cd_link_top (
	input  logic                       clk_sys,
	input  logic                       reset,

	// Host mailbox words
	input  cd_link_pkg::cd_host_word_t host_word,
	output cd_link_pkg::cd_core_word_t core_word,

	// Core requests
	input  logic                       comm_send,
	input  logic [`CD_CMD_W-1:0]       comm,
	input  logic                       dout_send,
	input  logic [`CD_DOUT_W-1:0]      dout,
	input  logic                       data_end,
	input  logic                       reset_req,
	input  logic                       fast_seek,

	// Sector download
	input  logic                       dl_active,
	input  cd_link_pkg::ioctl_t        dl,

	// Core side results
	output cd_link_pkg::cd_status_t    status,
	output logic                       stat_get,
	output logic                       dout_req,
	output logic                       region,
	output cd_link_pkg::cd_byte_t      cd_data
);

	// Host to core status path
	cd_host_rx host_rx (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host_word (host_word),
		.status    (status),
		.stat_get  (stat_get),
		.dout_req  (dout_req),
		.region    (region)
	);

	// Core to host event path
	cd_host_tx host_tx (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.comm_send (comm_send),
		.comm      (comm),
		.dout_send (dout_send),
		.dout      (dout),
		.data_end  (data_end),
		.reset_req (reset_req),
		.fast_seek (fast_seek),
		.core_word (core_word)
	);

	// Sector bytes into the core
	cd_data_streamer data_streamer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl        (dl),
		.cd_data   (cd_data)
	);

endmodule

//--- logic/cd_data_streamer.sv
// CD sector data streamer
// Reads the download header (data mode and word count), then splits
// each later 16-bit word into two byte writes to the core, low byte
// first, each marked by a one-cycle strobe

`timescale 1ns/1ps

`include "cd_link_macros.svh"

module cd_data_streamer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  cd_link_pkg::ioctl_t    dl,
	output cd_link_pkg::cd_byte_t  cd_data
);

	logic                 dl_active_q;
	logic                 dl_start;
	logic                 hdr_seen;
	logic                 mode;
	logic [`CD_LEN_W-1:0] len;
	// Counts bytes sent, upper bits give the word count
	logic [`CD_LEN_W:0]   byte_cnt;
	logic [15:0]          word_q;
	logic                 busy;
	logic                 byte_sel;
	logic                 wr_q;
	logic                 hdr_wr;
	logic                 take;

	//////////////////////////////////////////////////////////////////////
	// Download decode
	//////////////////////////////////////////////////////////////////////

	assign dl_start = dl_active & ~dl_active_q;
	assign hdr_wr   = dl.wr & dl_active & ~dl_start & ~hdr_seen;

	// No back-pressure, a word during a running sequence is lost
	assign take = dl.wr & dl_active & ~dl_start & hdr_seen & ~busy &
		(byte_cnt[`CD_LEN_W:1] < len);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			hdr_seen    <= 1'b0;
			mode        <= 1'b0;
			len         <= '0;
			byte_cnt    <= '0;
			busy        <= 1'b0;
			byte_sel    <= 1'b0;
			wr_q        <= 1'b0;
		end else begin
			dl_active_q <= dl_active;

			if (dl_start) begin
				hdr_seen <= 1'b0;
				len      <= '0;
				byte_cnt <= '0;
			end else if (hdr_wr) begin
				mode     <= dl.data[`CD_HDR_DM_BIT];
				len      <= dl.data[`CD_LEN_W-1:0];
				byte_cnt <= '0;
				hdr_seen <= 1'b1;
			end

			if (take) begin
				busy     <= 1'b1;
				byte_sel <= 1'b0;
			end

			// Strobe high one cycle, then low while the next byte is set up
			if (busy) begin
				if (!wr_q) begin
					wr_q <= 1'b1;
				end else begin
					wr_q     <= 1'b0;
					byte_sel <= ~byte_sel;
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_sel) begin
						busy <= 1'b0;
					end
				end
			end
		end
	end

	// Accepted data word
	always_ff @(posedge clk_sys) begin
		if (take) begin
			word_q <= dl.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Byte out
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		cd_data.data = byte_sel ? word_q[15:8] : word_q[7:0];
		cd_data.wr   = wr_q;
		cd_data.dm   = mode;
	end

endmodule

//--- logic/cd_host_tx.sv
// CD core to host mailbox
// Turns rising edges of the four core requests into a new outbound
// mailbox word and flips its toggle so the host sees a fresh event.
// Command, data-out, data end and reset are served in that order

`timescale 1ns/1ps

`include "cd_link_macros.svh"

module cd_host_tx (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       comm_send,
	input  logic [`CD_CMD_W-1:0]       comm,
	input  logic                       dout_send,
	input  logic [`CD_DOUT_W-1:0]      dout,
	input  logic                       data_end,
	input  logic                       reset_req,
	input  logic                       fast_seek,
	output cd_link_pkg::cd_core_word_t core_word
);

	import cd_link_pkg::*;

	// Registered copies for edge detect
	logic comm_q;
	logic dout_q;
	logic end_q;
	logic rst_q;

	logic comm_rise;
	logic dout_rise;
	logic end_rise;
	logic rst_rise;

	logic          send;
	cd_core_word_t word_next;

	assign comm_rise = comm_send & ~comm_q;
	assign dout_rise = dout_send & ~dout_q;
	assign end_rise  = data_end & ~end_q;
	assign rst_rise  = reset_req & ~rst_q;

	//////////////////////////////////////////////////////////////////////
	// Next word
	//////////////////////////////////////////////////////////////////////

	// Only the highest priority edge goes out, others are dropped
	always_comb begin
		word_next        = core_word;
		word_next.toggle = ~core_word.toggle;
		send             = 1'b1;
		if (comm_rise) begin
			word_next.code               = `CD_TYPE_CMD;
			word_next.code[`CD_SEEK_BIT] = fast_seek;
			word_next.payload            = comm;
		end else if (dout_rise) begin
			// Top of the payload keeps its old contents
			word_next.code                       = `CD_TYPE_DOUT;
			word_next.payload[`CD_DOUT_W-1:0]    = dout;
		end else if (end_rise) begin
			word_next.code = `CD_TYPE_END;
		end else if (rst_rise) begin
			word_next.code = `CD_TYPE_RESET;
		end else begin
			send = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comm_q    <= 1'b0;
			dout_q    <= 1'b0;
			end_q     <= 1'b0;
			rst_q     <= 1'b0;
			core_word <= '0;
		end else begin
			comm_q <= comm_send;
			dout_q <= dout_send;
			end_q  <= data_end;
			rst_q  <= reset_req;
			if (send) begin
				core_word <= word_next;
			end
		end
	end

endmodule

//--- logic/cd_host_rx.sv
// CD host mailbox decoder
// Watches the toggle bit of the inbound mailbox word and, on each
// change, latches status and region and pulses one strobe

`timescale 1ns/1ps

`include "cd_link_macros.svh"

module cd_host_rx (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  cd_link_pkg::cd_host_word_t host_word,
	output cd_link_pkg::cd_status_t   status,
	output logic                      stat_get,
	output logic                      dout_req,
	output logic                      region
);

	// Last toggle value seen from the host
	logic toggle_seen;
	logic new_msg;

	//////////////////////////////////////////////////////////////////////
	// Message detect
	//////////////////////////////////////////////////////////////////////

	// Any change of the toggle marks a fresh word
	assign new_msg = (host_word.toggle != toggle_seen);

	always_ff @(posedge clk_sys) begin
		// Strobes last one cycle only
		stat_get <= 1'b0;
		dout_req <= 1'b0;
		if (reset) begin
			toggle_seen <= 1'b1;
			region      <= 1'b0;
		end else if (new_msg) begin
			toggle_seen <= host_word.toggle;
			region      <= host_word.region;
			// Same layout for both, the flag picks the strobe
			stat_get    <= ~host_word.dout_flag;
			dout_req    <= host_word.dout_flag;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Status bytes
	//////////////////////////////////////////////////////////////////////

	// Held until the next message from the host
	always_ff @(posedge clk_sys) begin
		if (!reset && new_msg) begin
			status <= host_word.status;
		end
	end

endmodule

//--- logic/cd_link_pkg.sv
// CD-ROM host link types
// Mailbox word layouts in both directions, the status pair, the
// byte write to the core and the host download word

`include "cd_link_macros.svh"

package cd_link_pkg;

	// Message byte over status byte
	typedef struct packed {
		logic [7:0] msg;
		logic [7:0] stat;
	} cd_status_t;

	// Host to core mailbox word
	typedef struct packed {
		logic                  toggle;
		// Upper bits not used by this link
		logic [`CD_MSG_W-20:0] spare;
		logic                  region;
		// Set for a data-out request, clear for a status
		logic                  dout_flag;
		cd_status_t            status;
	} cd_host_word_t;

	// Core to host mailbox word
	typedef struct packed {
		logic                   toggle;
		logic [`CD_TYPE_W-1:0]  code;
		logic [`CD_CMD_W-1:0]   payload;
	} cd_core_word_t;

	// One sector byte to the core
	typedef struct packed {
		logic [7:0] data;
		logic       wr;
		logic       dm;
	} cd_byte_t;

	// Host download word with its write strobe
	typedef struct packed {
		logic        wr;
		logic [15:0] data;
	} ioctl_t;

endpackage

//--- include/cd_link_macros.svh
// CD-ROM host link constants
// Mailbox word widths, field positions and the type codes carried
// in the outbound mailbox word

`ifndef CD_LINK_MACROS_SVH
`define CD_LINK_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Both mailbox directions use the same word size
`define CD_MSG_W      113
`define CD_TYPE_W     16
`define CD_CMD_W      96
`define CD_DOUT_W     80
`define CD_LEN_W      15

//////////////////////////////////////////////////////////////////////
// Field positions
//////////////////////////////////////////////////////////////////////

// Fast seek flag inside the command type code
`define CD_SEEK_BIT   15
// Data-mode bit of the download header word
`define CD_HDR_DM_BIT 15

//////////////////////////////////////////////////////////////////////
// Outbound type codes
//////////////////////////////////////////////////////////////////////

`define CD_TYPE_CMD   16'h0000
`define CD_TYPE_DOUT  16'h0001
`define CD_TYPE_END   16'h0002
`define CD_TYPE_RESET 16'h00FF

`endif
